/* bench/cga_tb.sv */
// ******************************
// Testbench for the CPU gate array sheet
// A cycle model follows the sequencer, registers, flags
// and interrupt state, assertions compare it with the DUT
// on every falling clock edge
// ******************************

`timescale 1ns/1ns

module cga_tb;

   // Longest run stays under 200 cycles
   localparam int max_cycles = 400;

   logic                 aluclk;
   logic                 rst_n;
   cga_pkg::csbits_t     cs;
   cga_pkg::int_levels_t ibint_n;
   logic [15:0]          fidb_in;
   logic [15:0]          fidb_out;
   logic [12:0]          csa;
   logic [3:0]           pil;
   logic                 intrq_n;
   logic                 acond_n;

   string       test_name;
   int          mismatches;
   int          checked;
   integer      seed;
   logic [31:0] rnd;

   // Model state
   logic [12:0] m_csa;
   logic [15:0] m_regs [16];
   logic        m_z;
   logic        m_c;
   logic        m_s;
   logic [15:0] m_pend;
   logic [15:0] m_enab;
   logic [4:0]  m_samp;
   logic [4:0]  m_samp_d;

   // Model values derived each cycle
   logic [15:0] op_a;
   logic [15:0] op_b;
   logic [15:0] inv_b;
   logic        cin_v;
   logic [15:0] exp_res;
   logic        exp_carry;
   logic [15:0] exp_fidb;
   logic        exp_acond;
   logic [3:0]  exp_pil;
   logic [15:0] act;
   logic        found;
   logic [4:0]  fall_bits;
   logic [15:0] pend_nxt;

   tb_clock u_clk (
      .aluclk (aluclk),
      .rst_n  (rst_n)
   );

   cga_sheet dut (
      .aluclk   (aluclk),
      .rst_n    (rst_n),
      .cs       (cs),
      .ibint_n  (ibint_n),
      .fidb_in  (fidb_in),
      .fidb_out (fidb_out),
      .csa      (csa),
      .pil      (pil),
      .intrq_n  (intrq_n),
      .acond_n  (acond_n)
   );

   // Line bit to level, int10_n is the top bit
   function automatic int level_of(input int idx);
      case (idx)
         4: return 10;
         3: return 11;
         2: return 12;
         1: return 13;
         default: return 15;
      endcase
   endfunction

   function automatic cga_pkg::csbits_t make_word(
      input logic [4:0] comm, input logic [2:0] alu, input logic [1:0] rbsel,
      input logic [1:0] cinsel, input logic [4:0] idbs, input logic [1:0] cond,
      input logic [3:0] rb, input logic [15:0] lit);
      cga_pkg::csbits_t w;
      w = '0;
      w.comm = comm;
      w.alui = {6'd0, alu};
      w.rbsel = rbsel;
      w.cinsel = cinsel;
      w.idbs = idbs;
      w.ts = {2'b00, cond};
      w.rb = rb;
      w.lit.word = lit;
      return w;
   endfunction

   // One microcode word and bus value per clock
   task automatic issue(input cga_pkg::csbits_t w, input logic [15:0] data);
      @(posedge aluclk);
      cs <= w;
      fidb_in <= data;
   endtask

   // Low for one clock on the given lines, idle word meanwhile
   task automatic pulse_lines(input cga_pkg::int_levels_t lines_n);
      @(posedge aluclk);
      cs <= make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0);
      ibint_n <= lines_n;
      @(posedge aluclk);
      ibint_n <= '1;
   endtask

   // ALU model, subtract is A plus inverted B plus carry in
   always_comb begin
      op_a = m_regs[cs.rb];
      op_b = (cs.rbsel == 2'd0) ? fidb_in : cs.lit.word;
      inv_b = ~op_b;
      case (cs.cinsel)
         2'd0: cin_v = 1'b0;
         2'd1: cin_v = 1'b1;
         default: cin_v = m_c;
      endcase
      exp_carry = 1'b0;
      case (cs.alui[2:0])
         cga_pkg::alu_add: {exp_carry, exp_res} = 17'(op_a) + 17'(op_b) + 17'(cin_v);
         cga_pkg::alu_sub: {exp_carry, exp_res} = 17'(op_a) + 17'(inv_b) + 17'(cin_v);
         cga_pkg::alu_and: exp_res = op_a & op_b;
         cga_pkg::alu_or: exp_res = op_a | op_b;
         cga_pkg::alu_xor: exp_res = op_a ^ op_b;
         cga_pkg::alu_pass_a: exp_res = op_a;
         cga_pkg::alu_pass_b: exp_res = op_b;
         default: exp_res = 16'd0;
      endcase
   end

   // Highest level both pending and enabled
   always_comb begin
      act = m_pend & m_enab;
      exp_pil = 4'd0;
      found = 1'b0;
      for (int lvl = 15; lvl >= 1; lvl--) begin
         if (!found && act[lvl]) begin
            exp_pil = 4'(lvl);
            found = 1'b1;
         end
      end
   end

   // Bus, condition and next pending bits
   always_comb begin
      case (cs.idbs)
         cga_pkg::idbs_alu: exp_fidb = exp_res;
         cga_pkg::idbs_lit: exp_fidb = cs.lit.word;
         cga_pkg::idbs_pil: exp_fidb = {12'd0, exp_pil};
         default: exp_fidb = 16'd0;
      endcase
      case (cs.ts[1:0])
         cga_pkg::cond_zero: exp_acond = m_z;
         cga_pkg::cond_carry: exp_acond = m_c;
         cga_pkg::cond_sign: exp_acond = m_s;
         default: exp_acond = 1'b1;
      endcase
      fall_bits = m_samp_d & ~m_samp;
      pend_nxt = m_pend;
      if (cs.comm == cga_pkg::comm_clrpid) begin
         pend_nxt[exp_pil] = 1'b0;
      end
      // A new request beats the clear
      for (int i = 0; i < 5; i++) begin
         if (fall_bits[i]) begin
            pend_nxt[level_of(i)] = 1'b1;
         end
      end
   end

   always @(posedge aluclk) begin
      if (!rst_n) begin
         m_csa <= '0;
         for (int i = 0; i < 16; i++) begin
            m_regs[i] <= '0;
         end
         m_z <= 1'b0;
         m_c <= 1'b0;
         m_s <= 1'b0;
         m_pend <= '0;
         m_enab <= '0;
         m_samp <= '1;
         m_samp_d <= '1;
      end else begin
         if (cs.comm == cga_pkg::comm_jump || (cs.comm == cga_pkg::comm_cjump && exp_acond)) begin
            m_csa <= cs.lit.word[12:0];
         end else begin
            m_csa <= m_csa + 13'd1;
         end
         if (cs.comm == cga_pkg::comm_wrf) begin
            m_regs[cs.rb] <= exp_res;
            m_z <= (exp_res == 16'd0);
            m_c <= exp_carry;
            m_s <= exp_res[15];
         end
         if (cs.comm == cga_pkg::comm_setpie) begin
            m_enab <= fidb_in;
         end
         m_samp <= ibint_n;
         m_samp_d <= m_samp;
         m_pend <= pend_nxt;
      end
   end

   always @(negedge aluclk) begin
      if (rst_n) begin
         checked <= checked + 1;
      end
   end

   // Compared mid-cycle while everything is settled
   a_csa : assert property (@(negedge aluclk) disable iff (!rst_n) csa == m_csa)
      else begin
         mismatches = mismatches + 1;
         $display("MISMATCH %s csa expected %0h actual %0h", test_name, m_csa, csa);
      end

   a_fidb : assert property (@(negedge aluclk) disable iff (!rst_n) fidb_out == exp_fidb)
      else begin
         mismatches = mismatches + 1;
         $display("MISMATCH %s fidb_out expected %0h actual %0h", test_name, exp_fidb, fidb_out);
      end

   a_acond : assert property (@(negedge aluclk) disable iff (!rst_n) acond_n == !exp_acond)
      else begin
         mismatches = mismatches + 1;
         $display("MISMATCH %s acond_n expected %0b actual %0b", test_name, !exp_acond, acond_n);
      end

   a_pil : assert property (@(negedge aluclk) disable iff (!rst_n) pil == exp_pil)
      else begin
         mismatches = mismatches + 1;
         $display("MISMATCH %s pil expected %0d actual %0d", test_name, exp_pil, pil);
      end

   a_intrq : assert property (@(negedge aluclk) disable iff (!rst_n) intrq_n == (exp_pil == 4'd0))
      else begin
         mismatches = mismatches + 1;
         $display("MISMATCH %s intrq_n expected %0b actual %0b", test_name,
                  exp_pil == 4'd0, intrq_n);
      end

   initial begin
      repeat (max_cycles) @(posedge aluclk);
      $display("Timeout, testbench still running after %0d cycles", max_cycles);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      cs = '0;
      ibint_n = '1;
      fidb_in = 16'd0;
      mismatches = 0;
      checked = 0;
      seed = 32'h54a83c4a;
      test_name = "reset";
      wait (rst_n == 1'b1);
      repeat (2) issue(make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, 2'd0, 4'd0, 16'd0), 16'd0);

      // Spare bits set above the jump address
      test_name = "sequencer";
      repeat (5) issue(make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, 2'd0, 4'd0, 16'd0), 16'd0);
      issue(make_word(cga_pkg::comm_jump, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_lit, 2'd0, 4'd0, 16'heabc), 16'd0);
      repeat (2) issue(make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, 2'd0, 4'd0, 16'd0), 16'd0);
      // Wraps past the top address
      issue(make_word(cga_pkg::comm_jump, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, 2'd0, 4'd0, 16'h1ffe), 16'd0);
      repeat (4) issue(make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, 2'd0, 4'd0, 16'd0), 16'd0);

      test_name = "alu";
      for (int r = 0; r < 16; r++) begin
         rnd = $random(seed);
         issue(make_word(cga_pkg::comm_wrf, cga_pkg::alu_pass_b, 2'd1, 2'd0, cga_pkg::idbs_alu, 2'd0, 4'(r), rnd[15:0]), 16'd0);
      end
      repeat (3) begin
         for (int op = 0; op < 7; op++) begin
            rnd = $random(seed);
            issue(make_word(cga_pkg::comm_wrf, 3'(op), {1'b0, rnd[24]}, rnd[26:25], cga_pkg::idbs_alu, rnd[28:27], rnd[19:16], rnd[15:0]), rnd[31:16]);
         end
      end
      issue(make_word(cga_pkg::comm_nop, cga_pkg::alu_add, 2'd0, 2'd0, cga_pkg::idbs_alu, 2'd0, 4'd7, 16'd0), 16'h8001);
      issue(make_word(cga_pkg::comm_nop, cga_pkg::alu_sub, 2'd0, 2'd1, cga_pkg::idbs_alu, 2'd0, 4'd9, 16'd0), 16'h7ffe);
      issue(make_word(cga_pkg::comm_nop, cga_pkg::alu_add, 2'd0, 2'd0, cga_pkg::idbs_lit, 2'd0, 4'd0, 16'hc35a), 16'd0);

      // Zero result then taken and untaken conditional jumps
      test_name = "condition";
      issue(make_word(cga_pkg::comm_wrf, cga_pkg::alu_pass_b, 2'd1, 2'd0, cga_pkg::idbs_alu, 2'd0, 4'd3, 16'h1234), 16'd0);
      issue(make_word(cga_pkg::comm_wrf, cga_pkg::alu_sub, 2'd1, 2'd1, cga_pkg::idbs_alu, 2'd0, 4'd3, 16'h1234), 16'd0);
      issue(make_word(cga_pkg::comm_cjump, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, cga_pkg::cond_zero, 4'd0, 16'h0400), 16'd0);
      issue(make_word(cga_pkg::comm_wrf, cga_pkg::alu_pass_b, 2'd1, 2'd0, cga_pkg::idbs_alu, 2'd0, 4'd4, 16'd5), 16'd0);
      issue(make_word(cga_pkg::comm_wrf, cga_pkg::alu_sub, 2'd1, 2'd1, cga_pkg::idbs_alu, 2'd0, 4'd4, 16'd2), 16'd0);
      issue(make_word(cga_pkg::comm_cjump, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, cga_pkg::cond_zero, 4'd0, 16'h0800), 16'd0);
      issue(make_word(cga_pkg::comm_cjump, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, cga_pkg::cond_carry, 4'd0, 16'h0900), 16'd0);
      issue(make_word(cga_pkg::comm_cjump, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, cga_pkg::cond_sign, 4'd0, 16'h0a00), 16'd0);
      issue(make_word(cga_pkg::comm_cjump, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, cga_pkg::cond_true, 4'd0, 16'h0b00), 16'd0);

      // Level 11 masked first, then all levels enabled
      test_name = "interrupt";
      issue(make_word(cga_pkg::comm_setpie, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), 16'hb400);
      pulse_lines(5'b10111);
      repeat (3) issue(make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), 16'd0);
      pulse_lines(5'b01101);
      repeat (3) issue(make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), 16'd0);
      repeat (2) issue(make_word(cga_pkg::comm_clrpid, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), 16'd0);
      issue(make_word(cga_pkg::comm_setpie, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), 16'hffff);
      issue(make_word(cga_pkg::comm_clrpid, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), 16'd0);
      repeat (10) begin
         rnd = $random(seed);
         if (rnd[7]) begin
            issue(make_word(cga_pkg::comm_setpie, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), rnd[31:16]);
         end
         pulse_lines(rnd[4:0]);
         repeat (2) issue(make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), 16'd0);
         repeat (rnd[6:5]) issue(make_word(cga_pkg::comm_clrpid, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_pil, 2'd0, 4'd0, 16'd0), 16'd0);
      end

      test_name = "done";
      repeat (2) issue(make_word(cga_pkg::comm_nop, 3'd0, 2'd0, 2'd0, cga_pkg::idbs_none, 2'd0, 4'd0, 16'd0), 16'd0);
      @(posedge aluclk);
      $display("Checked %0d cycles, %0d mismatches", checked, mismatches);
      if (mismatches == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* bench/tb_clock.sv */
// ******************************
// Clock and reset for the testbench
// 8 ns aluclk, rst_n low for the first 3 rising edges
// ******************************

`timescale 1ns/1ns

module tb_clock (
   output logic aluclk,
   output logic rst_n
);

   initial begin
      aluclk = 1'b0;
      forever #4 aluclk = ~aluclk;
   end

   // Release on the third rising edge
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge aluclk);
      rst_n <= 1'b1;
   end

endmodule

/* cga/cga_alu.sv */
// ******************************
// ALU slice with 16 general registers
// Operand A is register rb, operand B the bus or literal
// Result and data bus are combinational, registers and
// zero, carry, sign flags load under the write command
// acond picks one flag for the sequencer
// ******************************

`timescale 1ns/1ns

module cga_alu (
   input  logic                       aluclk,
   input  logic                       rst_n,
   input  cga_pkg::csbits_t           cs,
   input  logic [cga_pkg::word_w-1:0] fidb_in,
   input  logic [3:0]                 pil,
   output logic [cga_pkg::word_w-1:0] fidb_out,
   output logic                       acond,
   output logic                       acond_n
);

   // Register file and flags
   logic [cga_pkg::word_w-1:0] regs [16];
   logic                       flag_z;
   logic                       flag_c;
   logic                       flag_s;

   logic [cga_pkg::word_w-1:0] op_a;
   logic [cga_pkg::word_w-1:0] op_b;
   logic                       cin;
   logic [cga_pkg::word_w:0]   res;

   assign op_a = regs[cs.rb];

   // Operand B from bus when rbsel is zero
   assign op_b = (cs.rbsel == cga_pkg::rbsel_bus) ? fidb_in : cs.lit.word;

   always_comb begin
      case (cs.cinsel)
         cga_pkg::cin_zero: cin = 1'b0;
         cga_pkg::cin_one:  cin = 1'b1;
         default:           cin = flag_c;
      endcase
   end

   // Bit 16 of res carries out of add and subtract only
   always_comb begin
      case (cs.alui[2:0])
         cga_pkg::alu_add:    res = {1'b0, op_a} + {1'b0, op_b} + {16'd0, cin};
         cga_pkg::alu_sub:    res = {1'b0, op_a} + {1'b0, ~op_b} + {16'd0, cin};
         cga_pkg::alu_and:    res = {1'b0, op_a & op_b};
         cga_pkg::alu_or:     res = {1'b0, op_a | op_b};
         cga_pkg::alu_xor:    res = {1'b0, op_a ^ op_b};
         cga_pkg::alu_pass_a: res = {1'b0, op_a};
         cga_pkg::alu_pass_b: res = {1'b0, op_b};
         default:             res = '0;
      endcase
   end

   // Register write and flag update
   always_ff @(posedge aluclk) begin
      if (!rst_n) begin
         for (int i = 0; i < 16; i++) begin
            regs[i] <= '0;
         end
         flag_z <= 1'b0;
         flag_c <= 1'b0;
         flag_s <= 1'b0;
      end else if (cs.comm == cga_pkg::comm_wrf) begin
         regs[cs.rb] <= res[cga_pkg::word_w-1:0];
         flag_z      <= (res[cga_pkg::word_w-1:0] == '0);
         flag_c      <= res[cga_pkg::word_w];
         flag_s      <= res[cga_pkg::word_w-1];
      end
   end

   // Data bus output mux
   always_comb begin
      case (cs.idbs)
         cga_pkg::idbs_none: fidb_out = '0;
         cga_pkg::idbs_alu:  fidb_out = res[cga_pkg::word_w-1:0];
         cga_pkg::idbs_lit:  fidb_out = cs.lit.word;
         // Current interrupt level, zero extended
         cga_pkg::idbs_pil:  fidb_out = {12'd0, pil};
         default:            fidb_out = '0;
      endcase
   end

   // Condition from registered flags
   always_comb begin
      case (cs.ts[1:0])
         cga_pkg::cond_zero:  acond = flag_z;
         cga_pkg::cond_carry: acond = flag_c;
         cga_pkg::cond_sign:  acond = flag_s;
         cga_pkg::cond_true:  acond = 1'b1;
         default:             acond = 1'b0;
      endcase
   end

   assign acond_n = ~acond;

   // Pin output stays the complement of the sequencer condition
   a_acond_pair : assert property (@(posedge aluclk) acond_n == !acond)
      else $error("alu: acond_n %0b with acond %0b", acond_n, acond);

endmodule

/* cga/cga_intr.sv */
// ******************************
// Interrupt detect for levels 10 to 13 and 15
// Lines are sampled each clock, a high to low step
// sets the pending bit one clock later
// pil is the highest level pending and enabled
// ******************************

`timescale 1ns/1ns

module cga_intr (
   input  logic                       aluclk,
   input  logic                       rst_n,
   input  cga_pkg::csbits_t           cs,
   input  logic [cga_pkg::word_w-1:0] fidb_in,
   input  cga_pkg::int_levels_t       ibint_n,
   output logic [3:0]                 pil,
   output logic                       intrq_n
);

   // Sampled lines, current and one clock older
   cga_pkg::int_levels_t samp;
   cga_pkg::int_levels_t samp_d;
   cga_pkg::int_levels_t fall;

   logic [15:0] pend;
   logic [15:0] enab;
   logic [15:0] set_mask;
   logic [15:0] clr_mask;
   logic [15:0] act;

   // Was high, now low
   assign fall = samp_d & ~samp;

   // Map lines onto their level bits, 14 has no line
   assign set_mask = {fall.int15_n, 1'b0, fall.int13_n, fall.int12_n,
                      fall.int11_n, fall.int10_n, 10'd0};

   // Acknowledge clears the level in service
   assign clr_mask = (cs.comm == cga_pkg::comm_clrpid) ? (16'd1 << pil) : 16'd0;

   always_ff @(posedge aluclk) begin
      if (!rst_n) begin
         samp   <= '1;
         samp_d <= '1;
         pend   <= '0;
         enab   <= '0;
      end else begin
         samp   <= ibint_n;
         samp_d <= samp;
         // New request wins over a clear in the same clock
         pend   <= (pend & ~clr_mask) | set_mask;
         if (cs.comm == cga_pkg::comm_setpie) begin
            enab <= fidb_in;
         end
      end
   end

   // Priority encoder, highest active bit
   assign act = pend & enab;

   always_comb begin
      pil = 4'd0;
      for (int i = 1; i < 16; i++) begin
         if (act[i]) begin
            pil = 4'(i);
         end
      end
   end

   assign intrq_n = (pil == 4'd0);

   // No request without a level
   a_no_req_idle : assert property (@(posedge aluclk) (pil == 4'd0) |-> intrq_n)
      else $error("intr: intrq_n low with pil 0");

endmodule

/* cga/cga_useq.sv */
// ******************************
// Microsequencer
// Holds the microcode address and steps it each clock
// Increments by default, loads the literal jump address
// on a jump or on a conditional jump with acond true
// ******************************

`timescale 1ns/1ns

module cga_useq (
   input  logic                       aluclk,
   input  logic                       rst_n,
   input  cga_pkg::csbits_t           cs,
   input  logic                       acond,
   output logic [cga_pkg::csa_w-1:0]  csa
);

   // Current address register
   logic [cga_pkg::csa_w-1:0] csa_r;
   logic [cga_pkg::csa_w-1:0] csa_nxt;
   logic                      take_jump;

   // Jump decision from command and condition
   always_comb begin
      take_jump = 1'b0;
      if (cs.comm == cga_pkg::comm_jump) begin
         take_jump = 1'b1;
      end else if (cs.comm == cga_pkg::comm_cjump) begin
         // Conditional, ALU picks the flag
         take_jump = acond;
      end
   end

   // Jump target from the address view of the literal
   always_comb begin
      if (take_jump) begin
         csa_nxt = cs.lit.jmp.jump_addr;
      end else begin
         // Wraps at 13 bits
         csa_nxt = csa_r + cga_pkg::csa_w'(1);
      end
   end

   always_ff @(posedge aluclk) begin
      if (!rst_n) begin
         csa_r <= '0;
      end else begin
         csa_r <= csa_nxt;
      end
   end

   assign csa = csa_r;

   // Jump lands on the previous word's target
   property p_jump_lands;
      @(posedge aluclk)
         (rst_n && cs.comm == cga_pkg::comm_jump)
            |=> (csa == $past(cs.lit.jmp.jump_addr));
   endproperty

   a_jump_lands : assert property (p_jump_lands)
      else $error("useq: csa %0h after jump, expected %0h",
                  csa, $past(cs.lit.jmp.jump_addr));

endmodule

/* common/cga_pkg.sv */
// ******************************
// Shared definitions for the CPU gate array sheet
// Holds the 64-bit microcode word layout, the literal
// union and the command, ALU, bus and condition codes
// Every block refers to these by scoped name
// ******************************

package cga_pkg;

   // Data and microcode address widths
   localparam int word_w = 16;
   localparam int csa_w = 13;

   // Command field codes
   localparam logic [4:0] comm_nop = 5'd0;
   localparam logic [4:0] comm_wrf = 5'd1;
   // Unconditional jump to literal address
   localparam logic [4:0] comm_jump = 5'd2;
   localparam logic [4:0] comm_cjump = 5'd3;
   // Interrupt enable load from bus
   localparam logic [4:0] comm_setpie = 5'd4;
   localparam logic [4:0] comm_clrpid = 5'd5;

   // ALU opcodes, low 3 bits of alui
   localparam logic [2:0] alu_add = 3'd0;
   localparam logic [2:0] alu_sub = 3'd1;
   localparam logic [2:0] alu_and = 3'd2;
   localparam logic [2:0] alu_or = 3'd3;
   localparam logic [2:0] alu_xor = 3'd4;
   localparam logic [2:0] alu_pass_a = 3'd5;
   localparam logic [2:0] alu_pass_b = 3'd6;

   // Internal data bus sources
   localparam logic [4:0] idbs_none = 5'd0;
   localparam logic [4:0] idbs_alu = 5'd1;
   localparam logic [4:0] idbs_lit = 5'd2;
   localparam logic [4:0] idbs_pil = 5'd3;

   // Condition select, low bits of ts
   localparam logic [1:0] cond_zero = 2'd0;
   localparam logic [1:0] cond_carry = 2'd1;
   localparam logic [1:0] cond_sign = 2'd2;
   localparam logic [1:0] cond_true = 2'd3;

   // Operand B source and carry-in select
   localparam logic [1:0] rbsel_bus = 2'd0;
   localparam logic [1:0] cin_zero = 2'd0;
   localparam logic [1:0] cin_one = 2'd1;

   // Low 16 bits of the word, data literal or jump target
   typedef union packed {
      logic [word_w-1:0] word;
      struct packed {
         logic [2:0]       spare;
         logic [csa_w-1:0] jump_addr;
      } jmp;
   } cs_lit_t;

   // Microcode word, bit 63 first
   typedef struct packed {
      logic [8:0] alui;
      logic [1:0] stss;
      logic [1:0] rasel;
      logic       xref3;
      logic [1:0] rbsel;
      logic [1:0] cinsel;
      logic [1:0] alum;
      logic [1:0] mis;
      logic [4:0] idbs;
      logic [4:0] comm;
      logic [3:0] ts;
      logic [1:0] delay;
      logic       vect;
      logic       scond;
      logic       econd;
      logic       loop;
      logic       dly;
      logic       bit20;
      logic [3:0] rb;
      cs_lit_t    lit;
   } csbits_t;

   // External interrupt lines, all active low
   typedef struct packed {
      logic int10_n;
      logic int11_n;
      logic int12_n;
      logic int13_n;
      logic int15_n;
   } int_levels_t;

endpackage

/* hw/cga_sheet.sv */
// ******************************
// CPU gate array sheet, top level
// Feeds the microcode word and the external interrupt
// lines into the sequencer, ALU and interrupt blocks
// All blocks run on aluclk
// ******************************

`timescale 1ns/1ns

module cga_sheet (
   input  logic                        aluclk,
   input  logic                        rst_n,
   input  cga_pkg::csbits_t            cs,
   input  cga_pkg::int_levels_t        ibint_n,
   input  logic [cga_pkg::word_w-1:0]  fidb_in,
   output logic [cga_pkg::word_w-1:0]  fidb_out,
   output logic [cga_pkg::csa_w-1:0]   csa,
   output logic [3:0]                  pil,
   output logic                        intrq_n,
   output logic                        acond_n
);

   // Selected condition, ALU to sequencer
   logic acond;

   // Next microcode address
   cga_useq u_useq (
      .aluclk (aluclk),
      .rst_n  (rst_n),
      .cs     (cs),
      .acond  (acond),
      .csa    (csa)
   );

   // Register file, ALU and bus output
   cga_alu u_alu (
      .aluclk   (aluclk),
      .rst_n    (rst_n),
      .cs       (cs),
      .fidb_in  (fidb_in),
      .pil      (pil),
      .fidb_out (fidb_out),
      .acond    (acond),
      .acond_n  (acond_n)
   );

   // Interrupt sampling and priority
   cga_intr u_intr (
      .aluclk  (aluclk),
      .rst_n   (rst_n),
      .cs      (cs),
      .fidb_in (fidb_in),
      .ibint_n (ibint_n),
      .pil     (pil),
      .intrq_n (intrq_n)
   );

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module cga_tb -o cga_sim \
   && ./obj_dir/cga_sim | tee /dev/stderr | grep -qx "All tests passed" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

/* src.f */
common/cga_pkg.sv
cga/cga_useq.sv
cga/cga_alu.sv
cga/cga_intr.sv
hw/cga_sheet.sv
bench/tb_clock.sv
bench/cga_tb.sv
